// ==== quick_spi.f ====
src/quick_spi_pkg.sv
src/quick_spi_axi.sv
src/quick_spi_regs.sv
src/quick_spi_engine.sv
src/quick_spi.sv
tests/quick_spi_tb.sv

// ==== Bender.yml ====
package:
  name: quick_spi

sources:
  - src/quick_spi_pkg.sv
  - src/quick_spi_axi.sv
  - src/quick_spi_regs.sv
  - src/quick_spi_engine.sv
  - src/quick_spi.sv
  - target: test
    files:
      - tests/quick_spi_tb.sv

// ==== tests/quick_spi_tb.sv ====
module quick_spi_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import quick_spi_pkg::*;

    localparam realtime clk_period      = 100.0;
    localparam int      buf_bits        = 208;   // 26 bytes in each buffer
    localparam int      num_rand_writes = 24;
    localparam int      num_transfers   = 5;
    localparam int      bus_op_cycles   = 8;
    localparam int      num_bus_ops     = 16 + 2 * num_rand_writes + num_transfers * 20 + 12;
    localparam int      xfer_max_cycles = 4 * buf_bits + 8;
    localparam int      watchdog_cycles = num_bus_ops * bus_op_cycles
                                          + num_transfers * xfer_max_cycles + 200;

    logic                  s_axi_aclk;
    logic                  s_axi_aresetn;
    logic [addr_width-1:0] s_axi_awaddr;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [data_width-1:0] s_axi_wdata;
    logic [strb_width-1:0] s_axi_wstrb;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [addr_width-1:0] s_axi_araddr;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [data_width-1:0] s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    logic                  sclk;
    logic                  mosi;
    logic                  miso;
    logic [num_slaves-1:0] ss_n;

    logic [7:0]            model [mem_bytes];   // what the register map should hold
    logic [223:0]          rx_pattern;
    logic [31:0]           rng_state;
    string                 cur_test;
    int                    errors;
    int                    checks;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;
    logic                  xfer_active;
    logic                  xfer_cpol;
    logic                  xfer_cpha;
    logic [num_slaves-1:0] exp_ss_n;
    int                    xfer_tx_bits;
    int                    edge_count;

    quick_spi quick_spi_i (.*);

    always #(clk_period / 2) s_axi_aclk = ~s_axi_aclk;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: the run went past %0d clock cycles and was stopped", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    function automatic logic [31:0] model_word(input int w);
        return {model[4 * w + 3], model[4 * w + 2], model[4 * w + 1], model[4 * w]};
    endfunction

    // transmit bits leave LSB first from the bottom of the transmit buffer
    function automatic logic expected_mosi(input int idx);
        return model[tx_buf_start + idx / 8][idx % 8];
    endfunction

    // received bits fill the receive buffer LSB first, bits past the count keep their value
    function automatic logic [7:0] expected_rx_byte(input int b, input int nbits);
        logic [7:0] value;
        value = model[rx_buf_start + b];
        for (int i = 0; i < 8; i++) begin
            if (8 * b + i < nbits) begin
                value[i] = rx_pattern[8 * b + i];
            end
        end
        return value;
    endfunction

    task automatic axi_write(input int word, input logic [31:0] data, input logic [3:0] strb);
        int   n;
        logic wready_seen;
        @(posedge s_axi_aclk);
        #1;
        s_axi_awaddr  = 8'(4 * word);
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
        end while (!s_axi_awready && n < 20);
        wready_seen = s_axi_wready;
        #1;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid && n < 20) begin
            @(posedge s_axi_aclk);
            n++;
        end
        if (n >= 20) begin
            report_failure("a write got no response from the bus");
        end else begin
            compare_values({cur_test, "_wready"}, 1'b1, wready_seen);
            compare_values({cur_test, "_bresp"}, 2'b00, s_axi_bresp);
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b] && 4 * word + b < rx_buf_start) begin
                model[4 * word + b] = data[8 * b +: 8];
            end
        end
    endtask

    task automatic read_check(input int word);
        int n;
        @(posedge s_axi_aclk);
        #1;
        s_axi_araddr  = 8'(4 * word);
        s_axi_arvalid = 1'b1;
        n = 0;
        do begin
            @(posedge s_axi_aclk);
            n++;
        end while (!s_axi_arready && n < 20);
        #1;
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid && n < 20) begin
            @(posedge s_axi_aclk);
            n++;
        end
        if (n >= 20) begin
            report_failure("a read got no data back from the bus");
        end else begin
            compare_values($sformatf("%s_word%0d", cur_test, word), model_word(word), s_axi_rdata);
            compare_values({cur_test, "_rresp"}, 2'b00, s_axi_rresp);
        end
    endtask

    // slave model, it samples mosi on the leading edge for cpha 0 and the trailing one for cpha 1
    always @(sclk) begin
        if (xfer_active && ss_n !== '1 && ((sclk != xfer_cpol) ^ xfer_cpha)) begin
            compare_values({cur_test, "_ss_n"}, exp_ss_n, ss_n);
            if (edge_count < xfer_tx_bits) begin
                compare_values($sformatf("%s_mosi%0d", cur_test, edge_count),
                               expected_mosi(edge_count), mosi);
            end
            edge_count++;
            if (edge_count >= xfer_tx_bits && edge_count - xfer_tx_bits < 224) begin
                miso = rx_pattern[edge_count - xfer_tx_bits];   // next receive bit goes out
            end
        end
    end

    task automatic run_transfer(input logic cpol, input logic cpha, input logic rd,
                                input int slave, input int tx_bits, input int rx_bits);
        logic [7:0] ctrl;
        int         n;
        ctrl = '0;
        ctrl[ctrl_cpol_bit] = cpol;
        ctrl[ctrl_cpha_bit] = cpha;
        ctrl[ctrl_read_bit] = rd;
        axi_write(0, {8'(tx_bits), 8'(tx_bits >> 8), 8'(slave), ctrl}, 4'hf);
        axi_write(1, {8'(rx_bits), 8'(rx_bits >> 8), 16'h0000}, 4'hf);
        for (int w = 3; w < 10; w++) begin
            axi_write(w, xorshift32(), 4'hf);
        end
        for (int i = 0; i < 7; i++) begin
            rx_pattern[32 * i +: 32] = xorshift32();
        end
        xfer_cpol     = cpol;
        xfer_cpha     = cpha;
        exp_ss_n      = '1;
        exp_ss_n[slave] = 1'b0;
        xfer_tx_bits  = tx_bits;
        edge_count    = 0;
        miso          = 1'b0;
        xfer_active   = 1'b1;
        ctrl[ctrl_start_bit] = 1'b1;
        axi_write(0, {24'h000000, ctrl}, 4'h1);
        n = 0;
        while (ss_n === '1 && n < 10) begin
            @(posedge s_axi_aclk);
            n++;
        end
        if (ss_n === '1) begin
            report_failure("no slave was selected after start was set");
        end else begin
            n = 0;
            while (ss_n !== '1 && n < 2 * (tx_bits + rx_bits) + 10) begin
                @(posedge s_axi_aclk);
                n++;
            end
            if (ss_n !== '1) begin
                report_failure("the slave select never went back high");
            end
        end
        xfer_active = 1'b0;
        compare_values({cur_test, "_sclk_idle"}, cpol, sclk);
        compare_values({cur_test, "_bit_count"}, tx_bits + (rd ? rx_bits : 0), edge_count);
        if (rd) begin
            for (int b = 0; b < 26; b++) begin
                model[rx_buf_start + b] = expected_rx_byte(b, rx_bits);
            end
        end
        model[0][ctrl_start_bit] = 1'b0;
        read_check(0);
        for (int w = 9; w < mem_words; w++) begin
            read_check(w);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] strb;
        int          w;
        s_axi_aclk    = 1'b0;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        miso          = 1'b0;
        rng_state     = 32'd45;
        xfer_active   = 1'b0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int i = 0; i < mem_bytes; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge s_axi_aclk);
        #1;
        s_axi_aresetn = 1'b1;

        start_test("reset");
        compare_values("reset_ss_n", {num_slaves{1'b1}}, ss_n);
        compare_values("reset_sclk", 1'b0, sclk);
        compare_values("reset_mosi_z", 1'b1, mosi === 1'bz);
        for (int i = 0; i < mem_words; i++) begin
            read_check(i);
        end
        finish_test();

        start_test("random_rw");
        for (int i = 0; i < num_rand_writes; i++) begin
            w    = int'(xorshift32() % 10);
            data = xorshift32();
            strb = xorshift32();
            if (w == 0) begin
                data[ctrl_start_bit] = 1'b0;   // keep the engine idle here
            end
            axi_write(w, data, strb[3:0]);
            read_check(w);
        end
        finish_test();

        start_test("mode0_tx");
        run_transfer(1'b0, 1'b0, 1'b0, 0, int'(xorshift32() % buf_bits) + 1, 16);
        finish_test();

        for (int m = 1; m < 4; m++) begin
            start_test($sformatf("mode%0d_rx", m));
            run_transfer(m[1], m[0], 1'b1, 0, int'(xorshift32() % 64) + 1,
                         int'(xorshift32() % buf_bits) + 1);
            finish_test();
        end

        start_test("slave1");
        run_transfer(1'b0, 1'b0, 1'b1, 1, 24, 40);
        for (int i = 10; i < mem_words; i++) begin
            axi_write(i, xorshift32(), 4'hf);   // receive area ignores the bus
            read_check(i);
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/quick_spi.sv ====
module quick_spi (
    input  logic                                    s_axi_aclk,
    input  logic                                    s_axi_aresetn,

    input  logic [quick_spi_pkg::addr_width-1:0]    s_axi_awaddr,
    input  logic                                    s_axi_awvalid,
    output logic                                    s_axi_awready,
    input  logic [quick_spi_pkg::data_width-1:0]    s_axi_wdata,
    input  logic [quick_spi_pkg::strb_width-1:0]    s_axi_wstrb,
    input  logic                                    s_axi_wvalid,
    output logic                                    s_axi_wready,
    output logic [1:0]                              s_axi_bresp,
    output logic                                    s_axi_bvalid,
    input  logic                                    s_axi_bready,

    input  logic [quick_spi_pkg::addr_width-1:0]    s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,
    output logic [quick_spi_pkg::data_width-1:0]    s_axi_rdata,
    output logic [1:0]                              s_axi_rresp,
    output logic                                    s_axi_rvalid,
    input  logic                                    s_axi_rready,

    output logic                                    sclk,
    output logic                                    mosi,
    input  logic                                    miso,
    output logic [quick_spi_pkg::num_slaves-1:0]    ss_n
);
    import quick_spi_pkg::*;

    reg_wr_t               reg_wr;
    word_addr_t            rd_addr;
    logic [data_width-1:0] rd_word;
    byte_addr_t            tx_addr;
    logic [7:0]            tx_byte;
    rx_bit_wr_t            rx_wr;
    logic                  done;
    spi_cfg_t              cfg;

    quick_spi_axi axi_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .reg_wr        (reg_wr),
        .rd_addr       (rd_addr),
        .rd_word       (rd_word)
    );

    quick_spi_regs regs_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .reg_wr        (reg_wr),
        .rd_addr       (rd_addr),
        .rd_word       (rd_word),
        .tx_addr       (tx_addr),
        .tx_byte       (tx_byte),
        .rx_wr         (rx_wr),
        .done          (done),
        .cfg           (cfg)
    );

    quick_spi_engine engine_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cfg           (cfg),
        .tx_addr       (tx_addr),
        .tx_byte       (tx_byte),
        .rx_wr         (rx_wr),
        .done          (done),
        .sclk          (sclk),
        .mosi          (mosi),
        .ss_n          (ss_n),
        .miso          (miso)
    );

endmodule

// ==== src/quick_spi_engine.sv ====
module quick_spi_engine (
    input  logic                                    s_axi_aclk,
    input  logic                                    s_axi_aresetn,

    input  quick_spi_pkg::spi_cfg_t                 cfg,
    output quick_spi_pkg::byte_addr_t               tx_addr,
    input  logic [7:0]                              tx_byte,
    output quick_spi_pkg::rx_bit_wr_t               rx_wr,
    output logic                                    done,

    output logic                                    sclk,
    output logic                                    mosi,
    output logic [quick_spi_pkg::num_slaves-1:0]    ss_n,
    input  logic                                    miso
);
    import quick_spi_pkg::*;

    spi_state_e state;
    spi_cfg_t   cfg_q;         // settings frozen for the duration of a transfer
    bit_count_t bit_cnt;       // bits completed in the current phase
    bit_count_t tx_idx;
    logic       rx_phase;
    logic       half;          // set on the second sclk edge of each bit
    logic       mosi_q;
    logic       mosi_en;
    logic       has_tx;
    logic       read_next;
    logic       phase_last;
    logic       launch;
    logic       sample;

    assign has_tx    = (cfg_q.tx_bits != '0);
    assign read_next = cfg_q.enable_read && (cfg_q.rx_bits != '0);

    assign phase_last = (bit_cnt == (rx_phase ? cfg_q.rx_bits : cfg_q.tx_bits) - 16'd1);

    // cpha 0 launches on the trailing edge and samples on the leading one, cpha 1 the reverse
    assign launch = (state == st_shift) && !rx_phase &&
                    (cfg_q.cpha ? !half : (half && !phase_last));
    assign sample = (state == st_shift) && rx_phase && (cfg_q.cpha ? half : !half);

    // in cpha 0 the trailing edge already puts out the following bit
    always_comb begin
        if (state == st_select) begin
            tx_idx = '0;
        end else if (cfg_q.cpha) begin
            tx_idx = bit_cnt;
        end else begin
            tx_idx = bit_cnt + 16'd1;
        end
    end

    assign tx_addr = byte_addr_t'(tx_buf_start) + tx_idx[3 +: byte_bits];

    assign rx_wr.en      = sample;
    assign rx_wr.addr    = byte_addr_t'(rx_buf_start) + bit_cnt[3 +: byte_bits];
    assign rx_wr.bit_idx = bit_cnt[2:0];
    assign rx_wr.value   = miso;

    assign done = (state == st_finish);
    assign mosi = mosi_en ? mosi_q : 1'bz;

    always_ff @(posedge s_axi_aclk) begin
        if (state == st_idle && cfg.start) begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state    <= st_idle;
            sclk     <= 1'b0;
            ss_n     <= '1;
            mosi_q   <= 1'b0;
            mosi_en  <= 1'b0;
            half     <= 1'b0;
            rx_phase <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    sclk <= cfg.cpol;   // idle level follows the programmed mode
                    if (cfg.start) begin
                        ss_n  <= ~(num_slaves'(1) << cfg.slave);
                        state <= st_select;
                    end
                end

                st_select: begin
                    mosi_en  <= 1'b1;
                    mosi_q   <= (!cfg_q.cpha && has_tx) ? tx_byte[tx_idx[2:0]] : 1'b0;
                    half     <= 1'b0;
                    bit_cnt  <= '0;
                    rx_phase <= !has_tx;   // a zero transmit count goes straight to reading
                    state    <= (has_tx || read_next) ? st_shift : st_finish;
                end

                st_shift: begin
                    sclk <= ~sclk;
                    half <= ~half;
                    if (launch) begin
                        mosi_q <= tx_byte[tx_idx[2:0]];
                    end
                    if (half) begin
                        if (!phase_last) begin
                            bit_cnt <= bit_cnt + 16'd1;
                        end else if (!rx_phase && read_next) begin
                            rx_phase <= 1'b1;
                            bit_cnt  <= '0;
                        end else begin
                            state <= st_finish;
                        end
                    end
                end

                st_finish: begin
                    sclk    <= cfg_q.cpol;
                    ss_n    <= '1;
                    mosi_en <= 1'b0;
                    state   <= st_idle;
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn) $onehot0(~ss_n))
        else $error("more than one slave selected");

    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (state == st_idle) |-> (ss_n == '1))
        else $error("slave still selected while idle");

endmodule

// ==== src/quick_spi_regs.sv ====
module quick_spi_regs (
    input  logic                                    s_axi_aclk,
    input  logic                                    s_axi_aresetn,

    input  quick_spi_pkg::reg_wr_t                  reg_wr,
    input  quick_spi_pkg::word_addr_t               rd_addr,
    output logic [quick_spi_pkg::data_width-1:0]    rd_word,

    input  quick_spi_pkg::byte_addr_t               tx_addr,
    output logic [7:0]                              tx_byte,
    input  quick_spi_pkg::rx_bit_wr_t               rx_wr,
    input  logic                                    done,

    output quick_spi_pkg::spi_cfg_t                 cfg
);
    import quick_spi_pkg::*;

    logic [7:0] mem [mem_bytes];

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            for (int i = 0; i < mem_bytes; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (reg_wr.en) begin
                for (int b = 0; b < strb_width; b++) begin
                    // the receive area silently drops bus writes
                    if (reg_wr.strb[b] && (int'(reg_wr.addr) * strb_width + b < rx_buf_start)) begin
                        mem[int'(reg_wr.addr) * strb_width + b] <= reg_wr.data[8*b +: 8];
                    end
                end
            end

            if (rx_wr.en) begin
                mem[rx_wr.addr][rx_wr.bit_idx] <= rx_wr.value;
            end

            // last assignment wins, so end of transfer beats a colliding bus write
            if (done) begin
                mem[ctrl_byte][ctrl_start_bit] <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < strb_width; b++) begin
            rd_word[8*b +: 8] = mem[int'(rd_addr) * strb_width + b];
        end
    end

    assign tx_byte = mem[tx_addr];

    assign cfg.cpol        = mem[ctrl_byte][ctrl_cpol_bit];
    assign cfg.cpha        = mem[ctrl_byte][ctrl_cpha_bit];
    assign cfg.start       = mem[ctrl_byte][ctrl_start_bit];
    assign cfg.enable_read = mem[ctrl_byte][ctrl_read_bit];
    assign cfg.slave       = slave_idx_t'(mem[slave_byte]);   // upper bits of the index byte are ignored
    assign cfg.tx_bits     = {mem[tx_bits_byte], mem[tx_bits_byte + 1]};
    assign cfg.rx_bits     = {mem[rx_bits_byte], mem[rx_bits_byte + 1]};

endmodule

// ==== src/quick_spi_axi.sv ====
module quick_spi_axi (
    input  logic                                    s_axi_aclk,
    input  logic                                    s_axi_aresetn,

    input  logic [quick_spi_pkg::addr_width-1:0]    s_axi_awaddr,
    input  logic                                    s_axi_awvalid,
    output logic                                    s_axi_awready,

    input  logic [quick_spi_pkg::data_width-1:0]    s_axi_wdata,
    input  logic [quick_spi_pkg::strb_width-1:0]    s_axi_wstrb,
    input  logic                                    s_axi_wvalid,
    output logic                                    s_axi_wready,

    output logic [1:0]                              s_axi_bresp,
    output logic                                    s_axi_bvalid,
    input  logic                                    s_axi_bready,

    input  logic [quick_spi_pkg::addr_width-1:0]    s_axi_araddr,
    input  logic                                    s_axi_arvalid,
    output logic                                    s_axi_arready,

    output logic [quick_spi_pkg::data_width-1:0]    s_axi_rdata,
    output logic [1:0]                              s_axi_rresp,
    output logic                                    s_axi_rvalid,
    input  logic                                    s_axi_rready,

    output quick_spi_pkg::reg_wr_t                  reg_wr,
    output quick_spi_pkg::word_addr_t               rd_addr,
    input  logic [quick_spi_pkg::data_width-1:0]    rd_word
);
    import quick_spi_pkg::*;

    logic                  wr_ready;
    logic                  bvalid_q;
    logic                  arready_q;
    logic                  rvalid_q;
    logic                  wr_accept;
    logic                  rd_accept;
    word_addr_t            rd_addr_q;
    logic [data_width-1:0] rdata_q;

    // address and data are taken together, a pending response holds off the next beat
    assign wr_accept = s_axi_awvalid && s_axi_wvalid && !wr_ready && !bvalid_q;
    assign rd_accept = s_axi_arvalid && !arready_q && !rvalid_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_ready <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_ready <= wr_accept;
            if (wr_ready) begin
                bvalid_q <= 1'b1;
            end else if (s_axi_bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= rd_accept;
            if (arready_q) begin
                rvalid_q <= 1'b1;
            end else if (s_axi_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (rd_accept) begin
            rd_addr_q <= s_axi_araddr[word_lsb +: word_bits];
        end
        if (arready_q) begin
            rdata_q <= rd_word;   // held here so rdata stays put under back-pressure
        end
    end

    // the write strobe is issued in the handshake cycle itself
    assign reg_wr.en   = wr_ready;
    assign reg_wr.addr = s_axi_awaddr[word_lsb +: word_bits];
    assign reg_wr.data = s_axi_wdata;
    assign reg_wr.strb = s_axi_wstrb;

    assign rd_addr = rd_addr_q;

    assign s_axi_awready = wr_ready;
    assign s_axi_wready  = wr_ready;
    assign s_axi_bresp   = axi_resp_okay;
    assign s_axi_bvalid  = bvalid_q;
    assign s_axi_arready = arready_q;
    assign s_axi_rdata   = rvalid_q ? rdata_q : '0;
    assign s_axi_rresp   = axi_resp_okay;
    assign s_axi_rvalid  = rvalid_q;

    property hold_until_ready(valid, ready);
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
            valid && !ready |=> valid;
    endproperty

    assert property (hold_until_ready(s_axi_bvalid, s_axi_bready))
        else $error("bvalid dropped before bready");
    assert property (hold_until_ready(s_axi_rvalid, s_axi_rready))
        else $error("rvalid dropped before rready");

endmodule

// ==== src/quick_spi_pkg.sv ====
package quick_spi_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 8;
    localparam int strb_width = data_width / 8;

    localparam int mem_bytes = 64;
    localparam int mem_words = 16;
    localparam int word_lsb  = $clog2(strb_width);   // byte lanes below the word index
    localparam int word_bits = $clog2(mem_words);
    localparam int byte_bits = $clog2(mem_bytes);

    typedef logic [word_bits-1:0] word_addr_t;
    typedef logic [byte_bits-1:0] byte_addr_t;
    typedef logic [15:0]          bit_count_t;

    // control area, bit counts are stored big-endian
    localparam int ctrl_byte    = 0;
    localparam int slave_byte   = 1;
    localparam int tx_bits_byte = 2;
    localparam int rx_bits_byte = 6;

    localparam int tx_buf_start = 12;
    localparam int rx_buf_start = 38;   // everything from here up is written only by the engine

    localparam int ctrl_cpol_bit  = 0;
    localparam int ctrl_cpha_bit  = 1;
    localparam int ctrl_start_bit = 2;
    localparam int ctrl_read_bit  = 4;

    localparam int num_slaves = 2;
    localparam int slave_bits = (num_slaves > 1) ? $clog2(num_slaves) : 1;
    typedef logic [slave_bits-1:0] slave_idx_t;

    localparam logic [1:0] axi_resp_okay = 2'b00;

    typedef struct packed {
        logic                  en;
        word_addr_t            addr;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } reg_wr_t;

    typedef struct packed {
        logic       cpol;
        logic       cpha;
        logic       start;
        logic       enable_read;
        slave_idx_t slave;
        bit_count_t tx_bits;
        bit_count_t rx_bits;
    } spi_cfg_t;

    // one received bit on its way into the receive buffer
    typedef struct packed {
        logic       en;
        byte_addr_t addr;
        logic [2:0] bit_idx;
        logic       value;
    } rx_bit_wr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_select,
        st_shift,
        st_finish
    } spi_state_e;

endpackage
